//--- logic/core_pkg.sv
// rv64i core types and encodings; only doubleword memory accesses, no csr or w-form opcodes.
`default_nettype none

package core_pkg;

  //////////////////////////////////////////////////
  // widths

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;   // register value.
  typedef logic [XLEN-1:0] addr_t;   // byte address.
  typedef logic [31:0]     inst_t;   // instruction word.
  typedef logic [4:0]      reg_idx_t;

  localparam addr_t RESET_PC = '0;

  //////////////////////////////////////////////////
  // major opcodes

  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] AUIPC  = 7'b0010111;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] JALR   = 7'b1100111;
  localparam logic [6:0] BRANCH = 7'b1100011;
  localparam logic [6:0] LOAD   = 7'b0000011;
  localparam logic [6:0] STORE  = 7'b0100011;
  localparam logic [6:0] SYSTEM = 7'b1110011;

  //////////////////////////////////////////////////
  // control encodings

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_JUMP
  } br_cond_e;

  typedef enum logic [1:0] {
    WB_ALU, WB_PC4, WB_LOAD
  } wb_sel_e;

  typedef enum logic [1:0] {
    ST_RUN, ST_WAIT_MEM, ST_HALTED
  } retire_state_e;

endpackage

`default_nettype wire

//--- logic/decode_unit.sv
// decodes the supported rv64i subset only; anything else is flagged illegal and requests a halt.
`default_nettype none
`timescale 1ns/100ps

module decode_unit import core_pkg::*; (
  input  wire         i_clk,
  input  wire         i_arst_n,
  input  inst_t       i_inst,
  input  wire         i_we,
  input  reg_idx_t    i_wr_idx,
  input  xlen_t       i_wr_data,
  output xlen_t       o_rs1_data,
  output xlen_t       o_rs2_data,
  output xlen_t       o_imm,
  output reg_idx_t    o_rd,
  output alu_op_e     o_alu_op,
  output logic        o_a_is_pc,
  output logic        o_b_is_imm,
  output br_cond_e    o_br_cond,
  output logic        o_jalr,
  output wb_sel_e     o_wb_sel,
  output logic        o_rd_we,
  output logic        o_load,
  output logic        o_store,
  output logic        o_halt_req,
  output logic        o_illegal
);

  xlen_t      regs [32];
  reg_idx_t   rs1, rs2;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       rd_we_raw;

  assign rs1    = i_inst[19:15];
  assign rs2    = i_inst[24:20];
  assign o_rd   = i_inst[11:7];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  //////////////////////////////////////////////////
  // register file

  always_ff @(posedge i_clk) begin
    if (i_we && i_wr_idx != '0) regs[i_wr_idx] <= i_wr_data;
  end

  assign o_rs1_data = (rs1 == '0) ? '0 : regs[rs1];   // x0 is hardwired to zero.
  assign o_rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  //////////////////////////////////////////////////
  // control decode

  always_comb begin
    o_imm      = '0;
    o_alu_op   = ALU_ADD;
    o_a_is_pc  = 1'b0;
    o_b_is_imm = 1'b0;
    o_br_cond  = BR_NONE;
    o_jalr     = 1'b0;
    o_wb_sel   = WB_ALU;
    rd_we_raw  = 1'b0;
    o_load     = 1'b0;
    o_store    = 1'b0;
    o_halt_req = 1'b0;
    o_illegal  = 1'b0;
    case (i_inst[6:0])
      OP_IMM: begin
        o_imm      = {{52{i_inst[31]}}, i_inst[31:20]};
        o_b_is_imm = 1'b1;
        rd_we_raw  = 1'b1;
        o_illegal  = funct3 != 3'b000;   // only addi.
      end
      OP: begin
        rd_we_raw = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: o_alu_op = ALU_ADD;
          {7'h20, 3'b000}: o_alu_op = ALU_SUB;
          {7'h00, 3'b111}: o_alu_op = ALU_AND;
          {7'h00, 3'b110}: o_alu_op = ALU_OR;
          {7'h00, 3'b100}: o_alu_op = ALU_XOR;
          {7'h00, 3'b010}: o_alu_op = ALU_SLT;
          {7'h00, 3'b011}: o_alu_op = ALU_SLTU;
          default:         o_illegal = 1'b1;
        endcase
      end
      LUI: begin
        o_imm      = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
        o_alu_op   = ALU_PASS_B;
        o_b_is_imm = 1'b1;
        rd_we_raw  = 1'b1;
      end
      AUIPC: begin
        o_imm      = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
        o_a_is_pc  = 1'b1;
        o_b_is_imm = 1'b1;
        rd_we_raw  = 1'b1;
      end
      JAL: begin
        o_imm     = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                     i_inst[30:21], 1'b0};
        o_br_cond = BR_JUMP;
        o_wb_sel  = WB_PC4;
        rd_we_raw = 1'b1;
      end
      JALR: begin
        o_imm     = {{52{i_inst[31]}}, i_inst[31:20]};
        o_br_cond = BR_JUMP;
        o_jalr    = 1'b1;
        o_wb_sel  = WB_PC4;
        rd_we_raw = 1'b1;
        o_illegal = funct3 != 3'b000;
      end
      BRANCH: begin
        o_imm = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                 i_inst[11:8], 1'b0};
        case (funct3)
          3'b000:  o_br_cond = BR_EQ;
          3'b001:  o_br_cond = BR_NE;
          3'b100:  o_br_cond = BR_LT;
          3'b101:  o_br_cond = BR_GE;
          default: o_illegal = 1'b1;
        endcase
      end
      LOAD: begin
        o_imm      = {{52{i_inst[31]}}, i_inst[31:20]};
        o_b_is_imm = 1'b1;
        o_wb_sel   = WB_LOAD;
        rd_we_raw  = 1'b1;
        o_load     = 1'b1;
        o_illegal  = funct3 != 3'b011;   // ld only.
      end
      STORE: begin
        o_imm      = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
        o_b_is_imm = 1'b1;
        o_store    = 1'b1;
        o_illegal  = funct3 != 3'b011;   // sd only.
      end
      SYSTEM: begin
        o_halt_req = 1'b1;
        o_illegal  = i_inst != 32'h0010_0073;   // ebreak is the only legal one.
      end
      default: o_illegal = 1'b1;
    endcase
    if (o_illegal) begin   // an illegal word must not touch state.
      rd_we_raw  = 1'b0;
      o_load     = 1'b0;
      o_store    = 1'b0;
      o_br_cond  = BR_NONE;
      o_halt_req = 1'b1;
    end
  end

  assign o_rd_we = rd_we_raw && o_rd != '0;

  a_load_store_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(o_load && o_store));

endmodule

`default_nettype wire

//--- logic/alu_unit.sv
// 64-bit integer alu for the supported subset; no shifts and no word-size results.
`default_nettype none
`timescale 1ns/100ps

module alu_unit import core_pkg::*; (
  input  xlen_t   i_rs1_data,
  input  xlen_t   i_rs2_data,
  input  xlen_t   i_imm,
  input  xlen_t   i_pc,
  input  alu_op_e i_alu_op,
  input  wire     i_a_is_pc,
  input  wire     i_b_is_imm,
  output xlen_t   o_result
);

  xlen_t op_a, op_b;

  assign op_a = i_a_is_pc  ? i_pc  : i_rs1_data;   // auipc adds to the pc.
  assign op_b = i_b_is_imm ? i_imm : i_rs2_data;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:    o_result = op_a + op_b;
      ALU_SUB:    o_result = op_a - op_b;
      ALU_AND:    o_result = op_a & op_b;
      ALU_OR:     o_result = op_a | op_b;
      ALU_XOR:    o_result = op_a ^ op_b;
      ALU_SLT:    o_result = {63'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   o_result = {63'b0, op_a < op_b};
      ALU_PASS_B: o_result = op_b;
      default:    o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
// branch resolution for beq, bne, blt, bge, jal and jalr; unsigned branches are not supported.
`default_nettype none
`timescale 1ns/100ps

module branch_unit import core_pkg::*; (
  input  xlen_t    i_rs1_data,
  input  xlen_t    i_rs2_data,
  input  xlen_t    i_imm,
  input  addr_t    i_pc,
  input  br_cond_e i_br_cond,
  input  wire      i_jalr,
  output logic     o_taken,
  output addr_t    o_target
);

  logic  equal, less;
  addr_t jalr_sum;

  assign equal    = i_rs1_data == i_rs2_data;
  assign less     = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign jalr_sum = i_rs1_data + i_imm;

  always_comb begin
    case (i_br_cond)
      BR_EQ:   o_taken = equal;
      BR_NE:   o_taken = !equal;
      BR_LT:   o_taken = less;
      BR_GE:   o_taken = !less;
      BR_JUMP: o_taken = 1'b1;
      default: o_taken = 1'b0;
    endcase
  end

  assign o_target = i_jalr ? {jalr_sum[63:1], 1'b0} : i_pc + i_imm;   // jalr drops bit 0.

endmodule

`default_nettype wire

//--- logic/lsu_axil.sv
// axi4-lite master, one doubleword transaction at a time; bresp and rresp are not checked.
`default_nettype none
`timescale 1ns/100ps

module lsu_axil import core_pkg::*; (
  input  wire        i_clk,
  input  wire        i_arst_n,
  input  wire        i_load,
  input  wire        i_store,
  input  addr_t      i_addr,
  input  xlen_t      i_wdata,
  output logic       o_done,
  output xlen_t      o_rdata,
  output logic       o_awvalid,
  input  wire        i_awready,
  output addr_t      o_awaddr,
  output logic       o_wvalid,
  input  wire        i_wready,
  output xlen_t      o_wdata,
  output logic [7:0] o_wstrb,
  input  wire        i_bvalid,
  output logic       o_bready,
  output logic       o_arvalid,
  input  wire        i_arready,
  output addr_t      o_araddr,
  input  wire        i_rvalid,
  output logic       o_rready,
  input  xlen_t      i_rdata
);

  typedef enum logic [1:0] {L_IDLE, L_STORE, L_LOAD} lsu_state_e;

  lsu_state_e state_q;
  logic       aw_done_q, w_done_q, ar_done_q;
  addr_t      addr_q;
  xlen_t      wdata_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= L_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      ar_done_q <= 1'b0;
    end else begin
      case (state_q)
        L_IDLE: begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          ar_done_q <= 1'b0;
          if (i_store)     state_q <= L_STORE;
          else if (i_load) state_q <= L_LOAD;
        end
        L_STORE: begin
          if (o_awvalid && i_awready) aw_done_q <= 1'b1;   // aw and w may finish apart.
          if (o_wvalid && i_wready)   w_done_q  <= 1'b1;
          if (i_bvalid)               state_q   <= L_IDLE;
        end
        L_LOAD: begin
          if (o_arvalid && i_arready) ar_done_q <= 1'b1;
          if (i_rvalid)               state_q   <= L_IDLE;
        end
        default: state_q <= L_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state_q == L_IDLE) begin   // payload held for the whole transaction.
      addr_q  <= i_addr;
      wdata_q <= i_wdata;
    end
  end

  assign o_awvalid = state_q == L_STORE && !aw_done_q;
  assign o_wvalid  = state_q == L_STORE && !w_done_q;
  assign o_bready  = state_q == L_STORE;
  assign o_arvalid = state_q == L_LOAD && !ar_done_q;
  assign o_rready  = state_q == L_LOAD;
  assign o_awaddr  = addr_q;
  assign o_araddr  = addr_q;
  assign o_wdata   = wdata_q;
  assign o_wstrb   = 8'hff;
  assign o_rdata   = i_rdata;
  assign o_done    = (state_q == L_STORE && i_bvalid) || (state_q == L_LOAD && i_rvalid);

  // a valid that has been raised stays up until its handshake.
  a_aw_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_awvalid && !i_awready |=> o_awvalid);
  a_w_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_wvalid && !i_wready |=> o_wvalid);
  a_ar_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_arvalid && !i_arready |=> o_arvalid);

endmodule

`default_nettype wire

//--- logic/retire_unit.sv
// single-issue retire; memory ops stall the pc until the lsu answers, halt is sticky until reset.
`default_nettype none
`timescale 1ns/100ps

module retire_unit import core_pkg::*; (
  input  wire      i_clk,
  input  wire      i_arst_n,
  input  xlen_t    i_alu_result,
  input  wire      i_taken,
  input  addr_t    i_target,
  input  wb_sel_e  i_wb_sel,
  input  reg_idx_t i_rd,
  input  wire      i_rd_we,
  input  wire      i_mem_op,
  input  wire      i_lsu_done,
  input  xlen_t    i_lsu_rdata,
  input  wire      i_halt_req,
  input  wire      i_illegal,
  output addr_t    o_pc,
  output logic     o_mem_go,
  output logic     o_rf_we,
  output reg_idx_t o_rf_idx,
  output xlen_t    o_rf_data,
  output logic     o_commit_valid,
  output addr_t    o_commit_pc,
  output reg_idx_t o_commit_rd,
  output logic     o_commit_we,
  output xlen_t    o_commit_data,
  output logic     o_halt,
  output logic     o_illegal
);

  retire_state_e state_q;
  addr_t         pc_q, pc_plus4;
  logic          illegal_q, commit;
  xlen_t         wb_data;

  assign pc_plus4 = pc_q + 64'd4;
  assign o_mem_go = state_q == ST_RUN && i_mem_op;   // one issue per memory instruction.
  assign commit   = i_arst_n && ((state_q == ST_RUN && !i_mem_op) ||
                                 (state_q == ST_WAIT_MEM && i_lsu_done));   // nothing retires in reset.

  always_comb begin
    case (i_wb_sel)
      WB_PC4:  wb_data = pc_plus4;   // link value.
      WB_LOAD: wb_data = i_lsu_rdata;
      default: wb_data = i_alu_result;
    endcase
  end

  //////////////////////////////////////////////////
  // state and pc

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= ST_RUN;
      pc_q      <= RESET_PC;
      illegal_q <= 1'b0;
    end else begin
      case (state_q)
        ST_RUN: begin
          if (i_halt_req) begin
            state_q   <= ST_HALTED;
            illegal_q <= i_illegal;
          end else if (i_mem_op) begin
            state_q <= ST_WAIT_MEM;
          end else begin
            pc_q <= i_taken ? i_target : pc_plus4;
          end
        end
        ST_WAIT_MEM: begin
          if (i_lsu_done) begin
            state_q <= ST_RUN;
            pc_q    <= pc_plus4;
          end
        end
        default: state_q <= ST_HALTED;
      endcase
    end
  end

  assign o_pc           = pc_q;
  assign o_rf_we        = commit && i_rd_we;
  assign o_rf_idx       = i_rd;
  assign o_rf_data      = wb_data;
  assign o_commit_valid = commit;
  assign o_commit_pc    = pc_q;
  assign o_commit_rd    = i_rd;
  assign o_commit_we    = o_rf_we;
  assign o_commit_data  = o_rf_we ? wb_data : '0;
  assign o_halt         = state_q == ST_HALTED;
  assign o_illegal      = illegal_q;

  // once halted the core stays halted and retires nothing more.
  a_halt_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_halt |=> o_halt && !o_commit_valid);

endmodule

`default_nettype wire

//--- logic/npc_core.sv
// core top; the instruction port is read combinationally and the data port is axi4-lite.
`default_nettype none
`timescale 1ns/100ps

module npc_core import core_pkg::*; (
  input  wire        i_clk,
  input  wire        i_arst_n,
  output addr_t      o_imem_addr,
  input  inst_t      i_imem_data,
  output logic       o_awvalid,
  input  wire        i_awready,
  output addr_t      o_awaddr,
  output logic       o_wvalid,
  input  wire        i_wready,
  output xlen_t      o_wdata,
  output logic [7:0] o_wstrb,
  input  wire        i_bvalid,
  output logic       o_bready,
  output logic       o_arvalid,
  input  wire        i_arready,
  output addr_t      o_araddr,
  input  wire        i_rvalid,
  output logic       o_rready,
  input  xlen_t      i_rdata,
  output logic       o_commit_valid,
  output addr_t      o_commit_pc,
  output reg_idx_t   o_commit_rd,
  output logic       o_commit_we,
  output xlen_t      o_commit_data,
  output logic       o_halt,
  output logic       o_illegal
);

  addr_t    pc, target;
  xlen_t    rs1_data, rs2_data, imm, alu_result, lsu_rdata, rf_data;
  reg_idx_t rd, rf_idx;
  alu_op_e  alu_op;
  br_cond_e br_cond;
  wb_sel_e  wb_sel;
  logic     a_is_pc, b_is_imm, jalr, rd_we, load, store, halt_req, illegal;
  logic     taken, lsu_done, mem_go, rf_we;

  wire mem_op   = load | store;
  wire lsu_load = load & mem_go;   // the retire unit issues each request once.
  wire lsu_st   = store & mem_go;

  assign o_imem_addr = pc;

  decode_unit u_decode (
    .i_clk(i_clk), .i_arst_n(i_arst_n), .i_inst(i_imem_data),
    .i_we(rf_we), .i_wr_idx(rf_idx), .i_wr_data(rf_data),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_imm(imm), .o_rd(rd),
    .o_alu_op(alu_op), .o_a_is_pc(a_is_pc), .o_b_is_imm(b_is_imm),
    .o_br_cond(br_cond), .o_jalr(jalr), .o_wb_sel(wb_sel), .o_rd_we(rd_we),
    .o_load(load), .o_store(store), .o_halt_req(halt_req), .o_illegal(illegal)
  );

  alu_unit u_alu (
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm), .i_pc(pc),
    .i_alu_op(alu_op), .i_a_is_pc(a_is_pc), .i_b_is_imm(b_is_imm),
    .o_result(alu_result)
  );

  branch_unit u_branch (
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm), .i_pc(pc),
    .i_br_cond(br_cond), .i_jalr(jalr), .o_taken(taken), .o_target(target)
  );

  lsu_axil u_lsu (
    .i_clk(i_clk), .i_arst_n(i_arst_n), .i_load(lsu_load), .i_store(lsu_st),
    .i_addr(alu_result), .i_wdata(rs2_data), .o_done(lsu_done), .o_rdata(lsu_rdata),
    .o_awvalid(o_awvalid), .i_awready(i_awready), .o_awaddr(o_awaddr),
    .o_wvalid(o_wvalid), .i_wready(i_wready), .o_wdata(o_wdata), .o_wstrb(o_wstrb),
    .i_bvalid(i_bvalid), .o_bready(o_bready),
    .o_arvalid(o_arvalid), .i_arready(i_arready), .o_araddr(o_araddr),
    .i_rvalid(i_rvalid), .o_rready(o_rready), .i_rdata(i_rdata)
  );

  retire_unit u_retire (
    .i_clk(i_clk), .i_arst_n(i_arst_n), .i_alu_result(alu_result),
    .i_taken(taken), .i_target(target), .i_wb_sel(wb_sel), .i_rd(rd),
    .i_rd_we(rd_we), .i_mem_op(mem_op), .i_lsu_done(lsu_done),
    .i_lsu_rdata(lsu_rdata), .i_halt_req(halt_req), .i_illegal(illegal),
    .o_pc(pc), .o_mem_go(mem_go), .o_rf_we(rf_we), .o_rf_idx(rf_idx),
    .o_rf_data(rf_data), .o_commit_valid(o_commit_valid), .o_commit_pc(o_commit_pc),
    .o_commit_rd(o_commit_rd), .o_commit_we(o_commit_we),
    .o_commit_data(o_commit_data), .o_halt(o_halt), .o_illegal(o_illegal)
  );

endmodule

`default_nettype wire

//--- verification/axil_mem_model.sv
// zeroed axi4-lite slave of 256 doublewords; strobes are ignored and every response is okay.
`default_nettype none
`timescale 1ns/100ps

module axil_mem_model import core_pkg::*; (
  input  wire   i_clk,
  input  wire   i_arst_n,
  input  wire   i_awvalid,
  output logic  o_awready,
  input  addr_t i_awaddr,
  input  wire   i_wvalid,
  output logic  o_wready,
  input  xlen_t i_wdata,
  output logic  o_bvalid,
  input  wire   i_bready,
  input  wire   i_arvalid,
  output logic  o_arready,
  input  addr_t i_araddr,
  output logic  o_rvalid,
  input  wire   i_rready,
  output xlen_t o_rdata
);

  xlen_t       mem [256];
  logic [31:0] lcg_q;
  logic [1:0]  delay_q;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    foreach (mem[i]) mem[i] = '0;
    lcg_q     = 32'h51ac;
    delay_q   = 2'd1;
    o_awready = 1'b0;
    o_wready  = 1'b0;
    o_bvalid  = 1'b0;
    o_arready = 1'b0;
    o_rvalid  = 1'b0;
    o_rdata   = '0;
  end

  // values seen at the falling edge are the ones the next rising edge samples.
  always @(negedge i_clk) begin
    logic  aw_rdy;
    logic  ar_rdy;
    logic  b_vld;
    logic  r_vld;
    xlen_t rdata_n;
    aw_rdy  = 1'b0;
    ar_rdy  = 1'b0;
    b_vld   = o_bvalid && !i_bready;
    r_vld   = o_rvalid && !i_rready;
    rdata_n = o_rdata;
    if (!i_arst_n) begin
      b_vld = 1'b0;
      r_vld = 1'b0;
    end else if (o_awready) begin   // aw and w are accepted together.
      mem[i_awaddr[10:3]] = i_wdata;
      b_vld = 1'b1;
    end else if (o_arready) begin
      rdata_n = mem[i_araddr[10:3]];
      r_vld   = 1'b1;
    end else if (!o_bvalid && !o_rvalid && ((i_awvalid && i_wvalid) || i_arvalid)) begin
      if (delay_q != 2'd0) begin
        delay_q = delay_q - 2'd1;
      end else begin
        aw_rdy  = i_awvalid && i_wvalid;
        ar_rdy  = i_arvalid && !aw_rdy;
        lcg_q   = lcg_step(lcg_q);
        delay_q = lcg_q[17:16];   // next request waits 0 to 3 cycles.
      end
    end
    @(posedge i_clk);
    #1;
    o_awready = aw_rdy;
    o_wready  = aw_rdy;
    o_arready = ar_rdy;
    o_bvalid  = b_vld;
    o_rvalid  = r_vld;
    o_rdata   = rdata_n;
  end

endmodule

`default_nettype wire

//--- verification/core_tb.sv
// self-checking core testbench; runs from the project root and reads verification/core_tests.txt.
`default_nettype none
`timescale 1ns/100ps

module core_tb import core_pkg::*; ();

  logic       clk;
  logic       arst_n;
  addr_t      imem_addr;
  inst_t      imem_data;
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  logic       arvalid, arready, rvalid, rready;
  addr_t      awaddr, araddr;
  xlen_t      wdata, rdata;
  logic [7:0] wstrb;
  logic       commit_valid, commit_we, halt, illegal;
  addr_t      commit_pc;
  reg_idx_t   commit_rd;
  xlen_t      commit_data;

  inst_t       rom [256];
  logic [63:0] tests [512];

  assign imem_data = rom[imem_addr[9:2]];   // word-addressed instruction rom.

  always #2 clk = ~clk;

  npc_core dut_i (
    .i_clk(clk), .i_arst_n(arst_n), .o_imem_addr(imem_addr), .i_imem_data(imem_data),
    .o_awvalid(awvalid), .i_awready(awready), .o_awaddr(awaddr),
    .o_wvalid(wvalid), .i_wready(wready), .o_wdata(wdata), .o_wstrb(wstrb),
    .i_bvalid(bvalid), .o_bready(bready),
    .o_arvalid(arvalid), .i_arready(arready), .o_araddr(araddr),
    .i_rvalid(rvalid), .o_rready(rready), .i_rdata(rdata),
    .o_commit_valid(commit_valid), .o_commit_pc(commit_pc), .o_commit_rd(commit_rd),
    .o_commit_we(commit_we), .o_commit_data(commit_data),
    .o_halt(halt), .o_illegal(illegal)
  );

  axil_mem_model mem_i (
    .i_clk(clk), .i_arst_n(arst_n),
    .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
    .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata),
    .o_bvalid(bvalid), .i_bready(bready),
    .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
    .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata)
  );

  //////////////////////////////////////////////////
  // checks

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic fail_with(input string why);
    $display("%s", why);
    abort_run();
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_strb(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // sequencing

  task automatic apply_reset();
    @(posedge clk);
    #1;
    arst_n = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_bit("o_awvalid", awvalid, 1'b0);
      check_bit("o_wvalid", wvalid, 1'b0);
      check_bit("o_arvalid", arvalid, 1'b0);
      check_bit("o_bready", bready, 1'b0);
      check_bit("o_rready", rready, 1'b0);
      check_bit("o_commit_valid", commit_valid, 1'b0);
      check_bit("o_halt", halt, 1'b0);
      check_bit("o_illegal", illegal, 1'b0);
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
  endtask

  task automatic run_section(input int base, input int n_exp, input logic exp_illegal);
    int   got;
    int   cycles;
    int   limit;
    int   rec;
    logic mem_seen;
    logic halted;
    limit    = n_exp * 20 + 50;
    got      = 0;
    cycles   = 0;
    mem_seen = 1'b0;
    halted   = 1'b0;
    apply_reset();
    while (!halted) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        fail_with($sformatf("timeout: no halt within %0d cycles", limit));
      end
      if (!mem_seen && (awvalid || wvalid || arvalid)) begin
        fail_with("an AXI valid rose before any load or store was fetched");
      end
      if (wvalid) check_strb("o_wstrb", wstrb, 8'hff);   // doubleword stores use every lane.
      if (imem_data[6:0] == LOAD || imem_data[6:0] == STORE) mem_seen = 1'b1;
      if (halt) begin
        halted = 1'b1;
      end else if (commit_valid) begin
        if (got >= n_exp) begin
          fail_with($sformatf("unexpected commit at pc 0x%h after the last expected one",
                              commit_pc));
        end
        rec = base + 4 * got;
        check_addr("o_commit_pc", commit_pc, tests[rec]);
        check_idx("o_commit_rd", commit_rd, tests[rec + 1][4:0]);
        check_bit("o_commit_we", commit_we, tests[rec + 2][0]);
        check_xlen("o_commit_data", commit_data, tests[rec + 3]);
        got++;
      end
    end
    if (got != n_exp) begin
      fail_with($sformatf("core halted after %0d commits, %0d were expected", got, n_exp));
    end
    check_bit("o_illegal", illegal, exp_illegal);
    repeat (4) begin   // halt is sticky and retires nothing more.
      @(negedge clk);
      check_bit("o_halt", halt, 1'b1);
      check_bit("o_commit_valid", commit_valid, 1'b0);
    end
  endtask

  initial begin
    int n_sec;
    int pos;
    int n_prog;
    int n_exp;
    clk    = 1'b0;
    arst_n = 1'b0;
    foreach (rom[i]) rom[i] = '0;
    foreach (tests[i]) tests[i] = '0;
    $readmemh("verification/core_tests.txt", tests);
    n_sec = int'(tests[0]);
    if (n_sec < 1) fail_with("the test data file holds no program section");
    pos = 1;
    for (int s = 0; s < n_sec; s++) begin
      n_prog = int'(tests[pos]);
      foreach (rom[i]) rom[i] = '0;
      for (int i = 0; i < n_prog; i++) rom[i] = tests[pos + 1 + i][31:0];
      pos   = pos + 1 + n_prog;
      n_exp = int'(tests[pos]);
      run_section(pos + 1, n_exp, tests[pos + 1 + 4 * n_exp][0]);
      pos = pos + 2 + 4 * n_exp;
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/core_tests.txt
// section count, then per section: word count, program words, commit count, commit records, halt kind
// commit record columns: pc rd write-flag data; halt kind 0 is ebreak, 1 is an illegal word
2
// section 1: alu ops, x0 write, branches, jal/jalr, sd then ld, ebreak
1B
00500093 FFD00113 002081B3 40208233
0020F2B3 0020E333 0020C3B3 00112433
001134B3 12345537 00001597 00708013
00008633 00C08463 00100693 00C09463
00114463 00100693 00115463 0080076F
00100693 05D007E7 00100693 04703023
04003803 04803883 00100073
17
00 01 1 5
04 02 1 FFFFFFFFFFFFFFFD
08 03 1 2
0C 04 1 8
10 05 1 5
14 06 1 FFFFFFFFFFFFFFFD
18 07 1 FFFFFFFFFFFFFFF8
1C 08 1 1
20 09 1 0
24 0A 1 12345000
28 0B 1 1028
2C 00 0 0
30 0C 1 5
34 08 0 0
3C 08 0 0
40 08 0 0
48 08 0 0
4C 0E 1 50
54 0F 1 58
5C 00 0 0
60 10 1 FFFFFFFFFFFFFFF8
64 11 1 0
68 00 0 0
0
// section 2: two writes, then an unsupported multiply
3
7FF00093 80000113 022081B3
3
00 01 1 7FF
04 02 1 FFFFFFFFFFFFF800
08 03 0 0
1

//--- all.f
logic/core_pkg.sv
logic/decode_unit.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/lsu_axil.sv
logic/retire_unit.sv
logic/npc_core.sv
verification/axil_mem_model.sv
verification/core_tb.sv

//--- Makefile
# Verilator build and run for the core testbench; run from the project root.

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)
DATA    := verification/core_tests.txt

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(DATA)
	./$(SIM) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
